/* shared_fifo_pkg.sv */
////////////////////
// Shared multi-FIFO package
// Sizes and index types used by every block of the shared FIFO
////////////////////

package shared_fifo_pkg;

  // Number of logical FIFOs that share the data RAM
  localparam int num_fifos_c = 4;

  // Number of shared RAM entries
  localparam int depth_c = 16;

  // Width of one data word
  localparam int width_c = 16;

  // Entry index into the RAM and the next-pointer table
  localparam int entry_w = $clog2(depth_c);

  // A per-FIFO count must be able to hold every entry, so one extra bit
  localparam int count_w = $clog2(depth_c + 1);

  // Logical FIFO selector carried with each push
  localparam int fid_w = $clog2(num_fifos_c);

  typedef logic [entry_w-1:0] entry_t;
  typedef logic [count_w-1:0] count_t;
  typedef logic [fid_w-1:0]   fid_t;

endpackage

/* shared_fifo_if.sv */
////////////////////
// Shared FIFO interfaces
// Per-FIFO head handshake and the single RAM read port
////////////////////

`timescale 1ns/1ps

// Head of each logical FIFO as offered by the list controller
interface head_if import shared_fifo_pkg::*; #(
  parameter int num_fifos = num_fifos_c
) ();

  logic   [num_fifos-1:0] head_valid;
  logic   [num_fifos-1:0] head_ready;
  entry_t [num_fifos-1:0] head;
  logic   [num_fifos-1:0] ram_empty;
  count_t [num_fifos-1:0] ram_items;

  modport source (output head_valid, head, ram_empty, ram_items, input head_ready);
  modport sink (input head_valid, head, ram_empty, ram_items, output head_ready);

endinterface

// Read port of the data RAM, data comes back one cycle after the address
interface ram_rd_if import shared_fifo_pkg::*; #(
  parameter int width = width_c
) ();

  logic             rd_addr_valid;
  entry_t           rd_addr;
  logic             rd_data_valid;
  logic [width-1:0] rd_data;

  modport requester (output rd_addr_valid, rd_addr, input rd_data_valid, rd_data);
  modport responder (input rd_addr_valid, rd_addr, output rd_data_valid, rd_data);

endinterface

/* shared_fifo_free_list.sv */
////////////////////
// Shared FIFO free list
// One free bit per RAM entry, hands out the lowest free entry
////////////////////

`timescale 1ns/1ps

module shared_fifo_free_list import shared_fifo_pkg::*; #(
  parameter int depth = depth_c
) (
  input  logic   clk,
  input  logic   rst_n,
  output logic   alloc_valid,
  input  logic   alloc_ready,
  output entry_t alloc_entry,
  input  logic   dealloc_valid,
  input  entry_t dealloc_entry
);

  // A set bit marks an entry that is free to hand out
  logic [depth-1:0] free_q;
  logic [depth-1:0] alloc_mask;
  logic [depth-1:0] dealloc_mask;

  // Scan from the top down so the lowest free entry wins
  always_comb begin
    alloc_entry = '0;
    for (int i = depth - 1; i >= 0; i--) begin
      if (free_q[i]) begin
        alloc_entry = entry_t'(i);
      end
    end
  end

  // Something is on offer as long as one entry is free
  assign alloc_valid = |free_q;

  always_comb begin
    alloc_mask   = '0;
    dealloc_mask = '0;
    if (alloc_valid && alloc_ready) begin
      alloc_mask[alloc_entry] = 1'b1;
    end
    if (dealloc_valid) begin
      dealloc_mask[dealloc_entry] = 1'b1;
    end
  end

  // An entry in use is never freed and handed out in the same cycle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      free_q <= '1;
    end else begin
      free_q <= (free_q & ~alloc_mask) | dealloc_mask;
    end
  end

endmodule

/* shared_fifo_list_ctrl.sv */
////////////////////
// Shared FIFO list controller
// Accepts pushes, writes the RAM and keeps a linked list per FIFO
////////////////////

`timescale 1ns/1ps

module shared_fifo_list_ctrl import shared_fifo_pkg::*; #(
  parameter int num_fifos = num_fifos_c,
  parameter int depth     = depth_c,
  parameter int width     = width_c
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             push_valid,
  output logic             push_ready,
  input  fid_t             push_fid,
  input  logic [width-1:0] push_data,
  input  logic             alloc_valid,
  output logic             alloc_ready,
  input  entry_t           alloc_entry,
  output logic             wr_en,
  output entry_t           wr_addr,
  output logic [width-1:0] wr_data,
  head_if.source           head_bus
);

  // Next pointer of each entry, valid only while the entry is linked
  entry_t next_q [depth];

  entry_t [num_fifos-1:0] tail_all;
  count_t [num_fifos-1:0] count_all;
  logic                   push_fire;
  logic   [num_fifos-1:0] pop_fire;

  // A push can go as soon as the free list has an entry to give
  assign push_ready  = alloc_valid;
  assign alloc_ready = push_valid;
  assign push_fire   = push_valid && alloc_valid;

  // The pushed word lands in the entry that was just allocated
  assign wr_en   = push_fire;
  assign wr_addr = alloc_entry;
  assign wr_data = push_data;

  assign pop_fire = head_bus.head_valid & head_bus.head_ready;

  // Hang the new entry behind the current tail of a non-empty list.
  // When the only item is popped in the same cycle this write lands on a
  // dead entry and is overwritten before that entry is linked again
  always_ff @(posedge clk) begin
    if (push_fire && (count_all[push_fid] != '0)) begin
      next_q[tail_all[push_fid]] <= alloc_entry;
    end
  end

  for (genvar f = 0; f < num_fifos; f++) begin : g_fifo
    entry_t head_q;
    entry_t tail_q;
    count_t count_q;
    logic   push_here;
    logic   take_head;

    assign push_here = push_fire && (push_fid == fid_t'(f));

    // The new entry is also the head if the list is empty after any pop
    assign take_head = push_here &&
                       ((count_q == '0) || ((count_q == count_t'(1)) && pop_fire[f]));

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        head_q  <= '0;
        tail_q  <= '0;
        count_q <= '0;
      end else begin
        if (take_head) begin
          head_q <= alloc_entry;
        end else if (pop_fire[f]) begin
          head_q <= next_q[head_q];
        end
        if (push_here) begin
          tail_q <= alloc_entry;
        end
        count_q <= count_q + count_t'(push_here) - count_t'(pop_fire[f]);
      end
    end

    assign tail_all[f]  = tail_q;
    assign count_all[f] = count_q;

    // Head shows up the cycle after the push that filled the list
    assign head_bus.head_valid[f] = (count_q != '0);
    assign head_bus.head[f]       = head_q;
    assign head_bus.ram_empty[f]  = (count_q == '0);
    assign head_bus.ram_items[f]  = count_q;
  end

endmodule

/* shared_fifo_pop_ctrl.sv */
////////////////////
// Shared FIFO pop controller
// Reads FIFO heads through the arbiter and stages data per FIFO
////////////////////

`timescale 1ns/1ps

module shared_fifo_pop_ctrl import shared_fifo_pkg::*; #(
  parameter int num_fifos   = num_fifos_c,
  parameter int width       = width_c,
  parameter int stage_depth = 2,
  parameter bit reg_dealloc = 1'b0
) (
  input  logic                             clk,
  input  logic                             rst_n,
  head_if.sink                             head_bus,
  ram_rd_if.requester                      rd_bus,
  output logic [num_fifos-1:0]             arb_request,
  input  logic [num_fifos-1:0]             arb_grant,
  output logic                             arb_update,
  output logic                             dealloc_valid,
  output entry_t                           dealloc_entry,
  output logic [num_fifos-1:0]             pop_valid,
  input  logic [num_fifos-1:0]             pop_ready,
  output logic [num_fifos-1:0][width-1:0]  pop_data,
  output logic [num_fifos-1:0]             pop_empty
);

  localparam int ptr_w = (stage_depth > 1) ? $clog2(stage_depth) : 1;
  localparam int cnt_w = $clog2(stage_depth + 1);

  logic [num_fifos-1:0] granted;
  fid_t                 grant_fid;
  entry_t               grant_head;
  logic                 pend_valid_q;
  fid_t                 pend_fid_q;

  // Circular pointer step that also works for depths that are not powers of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(stage_depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // The arbiter only grants requesters, masking keeps a stray grant harmless
  assign granted = arb_grant & arb_request;

  always_comb begin
    grant_fid  = '0;
    grant_head = '0;
    for (int i = 0; i < num_fifos; i++) begin
      if (granted[i]) begin
        grant_fid  = fid_t'(i);
        grant_head = head_bus.head[i];
      end
    end
  end

  // Read issue and head transfer happen together for the winner only
  assign head_bus.head_ready = granted;
  assign rd_bus.rd_addr_valid = |granted;
  assign rd_bus.rd_addr       = grant_head;
  assign arb_update           = rd_bus.rd_addr_valid;

  // Remember who owns the read that is in flight
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pend_valid_q <= 1'b0;
    end else begin
      pend_valid_q <= rd_bus.rd_addr_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_bus.rd_addr_valid) begin
      pend_fid_q <= grant_fid;
    end
  end

  for (genvar f = 0; f < num_fifos; f++) begin : g_stage
    logic [width-1:0] buf_q [stage_depth];
    logic [ptr_w-1:0] wr_ptr_q;
    logic [ptr_w-1:0] rd_ptr_q;
    logic [cnt_w-1:0] cnt_q;
    logic             inflight;
    logic             stg_push;
    logic             stg_pop;

    assign inflight = pend_valid_q && (pend_fid_q == fid_t'(f));
    assign stg_push = rd_bus.rd_data_valid && (pend_fid_q == fid_t'(f));
    assign stg_pop  = pop_valid[f] && pop_ready[f];

    // Ask for a read only while the buffer can take the word plus any in flight
    assign arb_request[f] = head_bus.head_valid[f] && (head_bus.ram_items[f] != '0) &&
                            ((int'(cnt_q) + int'(inflight)) < stage_depth);

    always_ff @(posedge clk) begin
      if (stg_push) begin
        buf_q[wr_ptr_q] <= rd_bus.rd_data;
      end
    end

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        wr_ptr_q <= '0;
        rd_ptr_q <= '0;
        cnt_q    <= '0;
      end else begin
        if (stg_push) begin
          wr_ptr_q <= ptr_inc(wr_ptr_q);
        end
        if (stg_pop) begin
          rd_ptr_q <= ptr_inc(rd_ptr_q);
        end
        cnt_q <= cnt_q + cnt_w'(stg_push) - cnt_w'(stg_pop);
      end
    end

    // Front word holds while the consumer stalls since rd_ptr does not move
    assign pop_valid[f] = (cnt_q != '0);
    assign pop_data[f]  = buf_q[rd_ptr_q];

    // A read on its way counts as buffered so the FIFO never looks empty early
    assign pop_empty[f] = head_bus.ram_empty[f] && (cnt_q == '0) && !inflight;
  end

  // Entries go back to the free list as soon as their read is issued
  if (reg_dealloc) begin : g_reg_dealloc
    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        dealloc_valid <= 1'b0;
      end else begin
        dealloc_valid <= rd_bus.rd_addr_valid;
      end
    end

    always_ff @(posedge clk) begin
      if (rd_bus.rd_addr_valid) begin
        dealloc_entry <= grant_head;
      end
    end
  end else begin : g_comb_dealloc
    assign dealloc_valid = rd_bus.rd_addr_valid;
    assign dealloc_entry = grant_head;
  end

endmodule

/* shared_fifo_rr_arbiter.sv */
////////////////////
// Round-robin arbiter
// Priority moves past the winner only on an update strobe
////////////////////

`timescale 1ns/1ps

module shared_fifo_rr_arbiter import shared_fifo_pkg::*; #(
  parameter int num_fifos = num_fifos_c
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [num_fifos-1:0] request,
  output logic [num_fifos-1:0] grant,
  input  logic                 update
);

  localparam int idx_w = (num_fifos > 1) ? $clog2(num_fifos) : 1;

  // Requester with the highest priority this cycle
  logic [idx_w-1:0] ptr_q;
  logic [idx_w-1:0] win_idx;

  // Walk backwards from the farthest slot so the first one at or after ptr_q wins
  always_comb begin
    int idx;
    win_idx = '0;
    for (int k = num_fifos - 1; k >= 0; k--) begin
      idx = (int'(ptr_q) + k) % num_fifos;
      if (request[idx]) begin
        win_idx = idx_w'(idx);
      end
    end
    for (int i = 0; i < num_fifos; i++) begin
      grant[i] = (|request) && (win_idx == idx_w'(i));
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (update && (|request)) begin
      ptr_q <= (win_idx == idx_w'(num_fifos - 1)) ? '0 : win_idx + 1'b1;
    end
  end

endmodule

/* shared_fifo_data_ram.sv */
////////////////////
// Shared FIFO data RAM
// One write port and one registered read port
////////////////////

`timescale 1ns/1ps

module shared_fifo_data_ram import shared_fifo_pkg::*; #(
  parameter int depth = depth_c,
  parameter int width = width_c
) (
  input  logic             clk,
  input  logic             wr_en,
  input  entry_t           wr_addr,
  input  logic [width-1:0] wr_data,
  ram_rd_if.responder      rd_bus
);

  logic [width-1:0] mem [depth];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read data and its valid follow the address by exactly one cycle.
  // The read entry is always allocated and the written one free, so the
  // two ports never touch the same word in one cycle
  always_ff @(posedge clk) begin
    rd_bus.rd_data_valid <= rd_bus.rd_addr_valid;
    if (rd_bus.rd_addr_valid) begin
      rd_bus.rd_data <= mem[rd_bus.rd_addr];
    end
  end

endmodule

/* shared_fifo_top.sv */
////////////////////
// Shared multi-FIFO top level
// Several logical FIFOs sharing one data RAM
////////////////////

`timescale 1ns/1ps

module shared_fifo_top import shared_fifo_pkg::*; #(
  parameter int num_fifos   = num_fifos_c,
  parameter int depth       = depth_c,
  parameter int width       = width_c,
  parameter int stage_depth = 2,
  parameter bit reg_dealloc = 1'b0
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            push_valid,
  output logic                            push_ready,
  input  fid_t                            push_fid,
  input  logic [width-1:0]                push_data,
  output logic [num_fifos-1:0]            pop_valid,
  input  logic [num_fifos-1:0]            pop_ready,
  output logic [num_fifos-1:0][width-1:0] pop_data,
  output logic [num_fifos-1:0]            pop_empty
);

  logic                 alloc_valid;
  logic                 alloc_ready;
  entry_t               alloc_entry;
  logic                 dealloc_valid;
  entry_t               dealloc_entry;
  logic                 wr_en;
  entry_t               wr_addr;
  logic [width-1:0]     wr_data;
  logic [num_fifos-1:0] arb_request;
  logic [num_fifos-1:0] arb_grant;
  logic                 arb_update;

  head_if #(.num_fifos(num_fifos)) head_bus ();
  ram_rd_if #(.width(width)) rd_bus ();

  shared_fifo_free_list #(.depth(depth)) free_list_i (.*);

  shared_fifo_list_ctrl #(.num_fifos(num_fifos), .depth(depth), .width(width)) list_ctrl_i (
    .clk, .rst_n, .push_valid, .push_ready, .push_fid, .push_data, .alloc_valid,
    .alloc_ready, .alloc_entry, .wr_en, .wr_addr, .wr_data, .head_bus(head_bus.source));

  shared_fifo_pop_ctrl #(.num_fifos(num_fifos), .width(width), .stage_depth(stage_depth),
    .reg_dealloc(reg_dealloc)) pop_ctrl_i (
    .clk, .rst_n, .head_bus(head_bus.sink), .rd_bus(rd_bus.requester), .arb_request,
    .arb_grant, .arb_update, .dealloc_valid, .dealloc_entry, .pop_valid, .pop_ready,
    .pop_data, .pop_empty);

  shared_fifo_rr_arbiter #(.num_fifos(num_fifos)) rr_arbiter_i (
    .clk, .rst_n, .request(arb_request), .grant(arb_grant), .update(arb_update));

  shared_fifo_data_ram #(.depth(depth), .width(width)) data_ram_i (
    .clk, .wr_en, .wr_addr, .wr_data, .rd_bus(rd_bus.responder));

endmodule

/* shared_fifo_properties.sv */
////////////////////
// Pop controller checks
// Grant, read issue, head and back-pressure rules
////////////////////

`timescale 1ns/1ps

module shared_fifo_properties import shared_fifo_pkg::*; #(
  parameter int num_fifos = num_fifos_c,
  parameter int width     = width_c
) (
  input logic                            clk,
  input logic                            rst_n,
  input logic [num_fifos-1:0]            head_valid,
  input logic [num_fifos-1:0]            head_ready,
  input logic [num_fifos-1:0]            ram_empty,
  input logic [num_fifos-1:0]            arb_grant,
  input logic                            rd_addr_valid,
  input logic [num_fifos-1:0]            pop_valid,
  input logic [num_fifos-1:0]            pop_ready,
  input logic [num_fifos-1:0][width-1:0] pop_data
);

  // Read by the testbench at the end of the run
  int unsigned fail_count = 0;

  // The arbiter picks at most one FIFO per cycle
  grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(arb_grant))
    else begin
      $error("arb_grant has more than one bit set");
      fail_count++;
    end

  // Every RAM read pulls a head off some FIFO in the same cycle
  read_has_head: assert property (@(posedge clk) disable iff (!rst_n)
    rd_addr_valid |-> |(head_valid & head_ready))
    else begin
      $error("RAM read issued without a head transfer");
      fail_count++;
    end

  // An empty list never offers a head
  head_not_empty: assert property (@(posedge clk) disable iff (!rst_n)
    !(|(head_valid & ram_empty)))
    else begin
      $error("head_valid high on an empty list");
      fail_count++;
    end

  for (genvar f = 0; f < num_fifos; f++) begin : g_hold
    // A stalled consumer sees the same word until it takes it
    pop_hold: assert property (@(posedge clk) disable iff (!rst_n)
      pop_valid[f] && !pop_ready[f] |=> pop_valid[f] && $stable(pop_data[f]))
      else begin
        $error("pop output changed under back-pressure on FIFO %0d", f);
        fail_count++;
      end
  end

endmodule

bind shared_fifo_pop_ctrl shared_fifo_properties #(
  .num_fifos(num_fifos),
  .width(width)
) props_i (
  .clk(clk),
  .rst_n(rst_n),
  .head_valid(head_bus.head_valid),
  .head_ready(head_bus.head_ready),
  .ram_empty(head_bus.ram_empty),
  .arb_grant(arb_grant),
  .rd_addr_valid(rd_bus.rd_addr_valid),
  .pop_valid(pop_valid),
  .pop_ready(pop_ready),
  .pop_data(pop_data)
);

/* tb_shared_fifo.sv */
////////////////////
// Shared multi-FIFO testbench
// Random pushes against a queue model per FIFO, checked at every pop
////////////////////

`timescale 1ns/1ps

module tb_shared_fifo import shared_fifo_pkg::*; ();

  localparam int clk_period    = 40;
  localparam int drive_delay   = 2;
  localparam int reset_cycles  = 10;
  localparam int stage_depth   = 2;
  localparam int single_pushes = 40;
  localparam int mixed_pushes  = 200;
  localparam int drain_limit   = 200;
  localparam int idle_cycles   = 5;
  localparam int max_accept    = depth_c + num_fifos_c * stage_depth;
  // Rough length of all tests in cycles, the watchdog allows twice as much
  localparam int stim_cycles   = reset_cycles + 2 * single_pushes + 5 * mixed_pushes +
                                 4 * (max_accept + drain_limit);

  logic                                clk;
  logic                                rst_n;
  logic                                push_valid;
  logic                                push_ready;
  fid_t                                push_fid;
  logic [width_c-1:0]                  push_data;
  logic [num_fifos_c-1:0]              pop_valid;
  logic [num_fifos_c-1:0]              pop_ready;
  logic [num_fifos_c-1:0][width_c-1:0] pop_data;
  logic [num_fifos_c-1:0]              pop_empty;

  integer             seed = 32'h10b4_e555;
  // Words pushed but not yet popped, oldest at index 0
  logic [width_c-1:0] model_q [num_fifos_c][$];
  int                 idle_cnt [num_fifos_c];
  logic               mixed_done;
  logic               full_seen;
  int                 accepted;

  shared_fifo_top #(.stage_depth(stage_depth)) shared_fifo_top_i (.*);

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    return $random(seed);
  endfunction

  // Expected word of the next pop on one FIFO
  function automatic logic [width_c-1:0] expected_pop(input int fid);
    return model_q[fid][0];
  endfunction

  function automatic int queued_words();
    int total;
    total = 0;
    for (int f = 0; f < num_fifos_c; f++) begin
      total += model_q[f].size();
    end
    return total;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("test failed");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, actual, expected));
    end
  endtask

  // Inputs always change a little after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #(drive_delay);
  endtask

  // Offer one word and hold it until the free list has room
  task automatic push_word(input fid_t fid, input logic [width_c-1:0] data);
    push_valid = 1'b1;
    push_fid   = fid;
    push_data  = data;
    @(negedge clk);
    while (!push_ready) begin
      @(negedge clk);
    end
    step_cycle();
    push_valid = 1'b0;
  endtask

  task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (queued_words() != 0) begin
      if (cycles >= drain_limit) begin
        abort_run("The FIFOs did not drain within the cycle limit");
      end else begin
        step_cycle();
        cycles++;
      end
    end
    // Idle time lets the empty flags settle and get checked
    repeat (idle_cycles + 1) step_cycle();
  endtask

  // Everything is sampled at the falling edge, half a cycle away from any change.
  // A handshake seen here completes at the next rising edge
  always @(negedge clk) begin
    if (!rst_n) begin
      for (int f = 0; f < num_fifos_c; f++) begin
        idle_cnt[f] = 0;
      end
    end else begin
      for (int f = 0; f < num_fifos_c; f++) begin
        if (model_q[f].size() == 0) begin
          idle_cnt[f]++;
          check_value($sformatf("pop_valid[%0d]", f), 32'(pop_valid[f]), 32'd0);
          if (idle_cnt[f] >= idle_cycles) begin
            check_value($sformatf("pop_empty[%0d]", f), 32'(pop_empty[f]), 32'd1);
          end
        end else begin
          idle_cnt[f] = 0;
          check_value($sformatf("pop_empty[%0d]", f), 32'(pop_empty[f]), 32'd0);
          if (pop_valid[f] && pop_ready[f]) begin
            check_value($sformatf("pop_data[%0d]", f), 32'(pop_data[f]),
                        32'(expected_pop(f)));
            void'(model_q[f].pop_front());
          end
        end
      end
      // A new word cannot pop in the cycle it is pushed, so it goes in last
      if (push_valid && push_ready) begin
        model_q[push_fid].push_back(push_data);
      end
    end
  end

  initial begin
    rst_n      = 1'b0;
    push_valid = 1'b0;
    push_fid   = '0;
    push_data  = '0;
    pop_ready  = '0;
    mixed_done = 1'b0;
    full_seen  = 1'b0;
    accepted   = 0;
    repeat (reset_cycles) @(posedge clk);
    #(drive_delay);
    rst_n = 1'b1;

    // All entries free and nothing to pop right after reset
    @(negedge clk);
    check_value("push_ready", 32'(push_ready), 32'd1);
    check_value("pop_valid", 32'(pop_valid), 32'd0);
    check_value("pop_empty", 32'(pop_empty), 32'((1 << num_fifos_c) - 1));
    step_cycle();

    // One FIFO with a consumer that is always ready
    pop_ready = '1;
    for (int i = 0; i < single_pushes; i++) begin
      push_word(fid_t'(0), width_c'(next_random()));
    end
    wait_drain();

    // All FIFOs mixed, random gaps and random consumer stalls
    fork
      begin
        for (int i = 0; i < mixed_pushes; i++) begin
          repeat (next_random() % 4) step_cycle();
          push_word(fid_t'(next_random()), width_c'(next_random()));
        end
        mixed_done = 1'b1;
      end
      begin
        while (!mixed_done) begin
          pop_ready = num_fifos_c'(next_random());
          step_cycle();
        end
      end
    join
    pop_ready = '1;
    wait_drain();

    // Fill with every consumer stalled until the free list runs dry
    pop_ready  = '0;
    push_valid = 1'b1;
    while (!full_seen && (accepted <= max_accept)) begin
      push_fid  = fid_t'(next_random());
      push_data = width_c'(next_random());
      @(negedge clk);
      if (push_ready) begin
        accepted++;
      end else begin
        full_seen = 1'b1;
      end
      step_cycle();
    end
    push_valid = 1'b0;
    if (!full_seen || (accepted < depth_c) || (accepted > max_accept)) begin
      abort_run($sformatf("push_ready first went low after %0d pushes, out of range",
                          accepted));
    end
    pop_ready = '1;
    wait_drain();

    // A full drain must have handed every entry back
    pop_ready = '0;
    for (int i = 0; i < depth_c; i++) begin
      push_valid = 1'b1;
      push_fid   = fid_t'(next_random());
      push_data  = width_c'(next_random());
      @(negedge clk);
      if (!push_ready) begin
        abort_run("A push was refused after a full drain, popped entries were not freed");
      end else begin
        step_cycle();
      end
    end
    push_valid = 1'b0;
    pop_ready  = '1;
    wait_drain();

    if (shared_fifo_top_i.pop_ctrl_i.props_i.fail_count == 0) begin
      $display("test passed");
      $finish;
    end else begin
      abort_run("A concurrent assertion on the pop controller failed");
    end
  end

  initial begin
    #(2 * stim_cycles * clk_period);
    abort_run($sformatf("Timeout, the tests did not finish within %0d cycles",
                        2 * stim_cycles));
  end

endmodule

/* tb.f */
shared_fifo_pkg.sv
shared_fifo_if.sv
shared_fifo_free_list.sv
shared_fifo_list_ctrl.sv
shared_fifo_pop_ctrl.sv
shared_fifo_rr_arbiter.sv
shared_fifo_data_ram.sv
shared_fifo_top.sv
shared_fifo_properties.sv
tb_shared_fifo.sv

/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= tb_shared_fifo
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
	  echo "simulation FAILED"; exit 1; \
	else \
	  echo "simulation PASSED"; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
